/* all.f */
design/aes_pkg.sv
design/aes_key_reg.sv
design/aes_credit_ctrl.sv
design/aes_round_stage.sv
design/aes_encrypt_top.sv
tb/aes_tb_asserts.sv
tb/aes_tb.sv

/* design/aes_credit_ctrl.sv */
// ============================================================
// credit counter for the output sink, CREDITS from 1 to 15
// returns beyond CREDITS are a sink error and are not filtered
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_credit_ctrl #(
   parameter int CREDITS = 4
) (
   input  logic clk,
   input  logic nRst,
   input  logic in_valid,
   input  logic credit_return,
   output logic in_ready,
   output logic accept
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   logic [CNT_W-1:0] credit_cnt;  // free sink slots not yet claimed

   // pipeline cannot stall, so input waits for a credit
   assign in_ready = (credit_cnt != '0);
   assign accept   = in_valid & in_ready;  // valid bit of stage 0

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         credit_cnt <= CNT_W'(CREDITS);
      end else begin
         case ({accept, credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;  // block taken
            2'b01:   credit_cnt <= credit_cnt + 1'b1;  // slot freed downstream
            default: ;                                 // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/aes_encrypt_top.sv */
// ============================================================
// pipelined AES-128 encrypt, 11 cycles from accept to out_valid
// out_valid is a one-cycle pulse, the sink must take it then
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_encrypt_top import aes_pkg::*; #(
   parameter int CREDITS = 4
) (
   input  logic       clk,
   input  logic       nRst,
   input  logic       key_load,
   input  aes_block_t key_in,
   input  logic       in_valid,
   input  aes_block_t in_block,
   output logic       in_ready,
   output logic       out_valid,
   output aes_block_t out_block,
   input  logic       credit_return
);

   aes_block_t cipher_key;
   logic       accept;

   // entry 0 feeds stage 0, entry k+1 is the output of stage k
   logic       valid_chain [0:AES_LATENCY];
   aes_block_t block_chain [0:AES_LATENCY];
   aes_block_t key_chain   [0:AES_LATENCY];

   aes_key_reg u_key_reg (
      .clk        (clk),
      .nRst       (nRst),
      .key_load   (key_load),
      .key_in     (key_in),
      .cipher_key (cipher_key)
   );

   aes_credit_ctrl #(
      .CREDITS (CREDITS)
   ) u_credit (
      .clk           (clk),
      .nRst          (nRst),
      .in_valid      (in_valid),
      .credit_return (credit_return),
      .in_ready      (in_ready),
      .accept        (accept)
   );

   assign valid_chain[0] = accept;
   assign block_chain[0] = in_block;
   assign key_chain[0]   = cipher_key;

   for (genvar i = 0; i < AES_LATENCY; i++) begin : g_stage
      aes_round_stage #(
         .ROUND      (i),
         .NUM_ROUNDS (AES_NUM_ROUNDS)
      ) u_stage (
         .clk       (clk),
         .nRst      (nRst),
         .valid_in  (valid_chain[i]),
         .block_in  (block_chain[i]),
         .key_in    (key_chain[i]),
         .valid_out (valid_chain[i+1]),
         .block_out (block_chain[i+1]),
         .key_out   (key_chain[i+1])
      );
   end

   assign out_valid = valid_chain[AES_LATENCY];
   assign out_block = block_chain[AES_LATENCY];  // ciphertext

endmodule

`default_nettype wire

/* design/aes_key_reg.sv */
// ============================================================
// cipher key config register, cleared to zero on reset
// a write lands one cycle after key_load, blocks in flight keep theirs
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_key_reg import aes_pkg::*; (
   input  logic       clk,
   input  logic       nRst,
   input  logic       key_load,
   input  aes_block_t key_in,
   output aes_block_t cipher_key
);

   // key for blocks entering stage 0
   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         cipher_key <= '0;
      end else if (key_load) begin
         cipher_key <= key_in;  // seen by accepts from next cycle on
      end
   end

endmodule

`default_nettype wire

/* design/aes_pkg.sv */
// ============================================================
// AES-128 only; blocks and keys are stored column-major as in FIPS-197
// byte 0 of the standard is the MSB byte of the 128-bit vector
// ============================================================
`default_nettype none

package aes_pkg;

   typedef logic [0:3][7:0] aes_word_t;   // one column, row 0 first
   typedef aes_word_t [0:3] aes_block_t;  // blk[col][row]

   localparam int AES_NUM_ROUNDS = 10;
   localparam int AES_LATENCY    = AES_NUM_ROUNDS + 1;  // key add plus the rounds

   // forward s-box, entry 0 is the most significant byte
   localparam logic [0:255][7:0] AES_SBOX = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
   };

   function automatic logic [7:0] aes_sbox(input logic [7:0] b);
      return AES_SBOX[b];
   endfunction

   // round constant for key expansion, rounds 1 to 10
   function automatic logic [7:0] aes_rcon(input int round);
      logic [7:0] rc;
      case (round)
         1:       rc = 8'h01;
         2:       rc = 8'h02;
         3:       rc = 8'h04;
         4:       rc = 8'h08;
         5:       rc = 8'h10;
         6:       rc = 8'h20;
         7:       rc = 8'h40;
         8:       rc = 8'h80;
         9:       rc = 8'h1b;
         10:      rc = 8'h36;
         default: rc = 8'h00;  // no constant outside the schedule
      endcase
      return rc;
   endfunction

   // multiply by 2 in GF(2^8), x^8 folded back as 1b
   function automatic logic [7:0] aes_xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   // multiply by 3 = 2b + b
   function automatic logic [7:0] aes_mul3(input logic [7:0] b);
      return aes_xtime(b) ^ b;
   endfunction

endpackage

`default_nettype wire

/* design/aes_round_stage.sv */
// ============================================================
// one registered AES-128 stage, stage 0 is the initial key add
// the round key is expanded here and travels with the block
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_round_stage import aes_pkg::*; #(
   parameter int ROUND      = 0,
   parameter int NUM_ROUNDS = AES_NUM_ROUNDS
) (
   input  logic       clk,
   input  logic       nRst,
   input  logic       valid_in,
   input  aes_block_t block_in,
   input  aes_block_t key_in,
   output logic       valid_out,
   output aes_block_t block_out,
   output aes_block_t key_out
);

   aes_block_t round_key;   // key of this round, also handed on
   aes_block_t state_next;

   // one column times the fixed MixColumns matrix
   function automatic aes_word_t mix_column(input aes_word_t a);
      aes_word_t m;
      m[0] = aes_xtime(a[0]) ^ aes_mul3(a[1]) ^ a[2] ^ a[3];
      m[1] = a[0] ^ aes_xtime(a[1]) ^ aes_mul3(a[2]) ^ a[3];
      m[2] = a[0] ^ a[1] ^ aes_xtime(a[2]) ^ aes_mul3(a[3]);
      m[3] = aes_mul3(a[0]) ^ a[1] ^ a[2] ^ aes_xtime(a[3]);
      return m;
   endfunction

   if (ROUND == 0) begin : g_initial
      assign round_key  = key_in;             // cipher key passes unchanged
      assign state_next = block_in ^ key_in;
   end else begin : g_round
      aes_word_t  rot_word;
      aes_word_t  sub_word;
      aes_block_t sub_bytes;
      aes_block_t shift_rows;
      aes_block_t mix_cols;

      // next round key from the previous one
      always_comb begin
         rot_word = {key_in[3][1], key_in[3][2], key_in[3][3], key_in[3][0]};
         for (int r = 0; r < 4; r++) begin
            sub_word[r] = aes_sbox(rot_word[r]);
         end
         sub_word[0]  = sub_word[0] ^ aes_rcon(ROUND);
         round_key[0] = key_in[0] ^ sub_word;
         for (int c = 1; c < 4; c++) begin
            round_key[c] = key_in[c] ^ round_key[c-1];  // chained column xor
         end
      end

      always_comb begin
         for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
               sub_bytes[c][r] = aes_sbox(block_in[c][r]);
            end
         end
         // row r rotates left by r bytes
         for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
               shift_rows[c][r] = sub_bytes[(c + r) % 4][r];
            end
         end
         for (int c = 0; c < 4; c++) begin
            mix_cols[c] = mix_column(shift_rows[c]);
         end
      end

      // final round has no MixColumns
      assign state_next = (ROUND == NUM_ROUNDS) ? (shift_rows ^ round_key)
                                                : (mix_cols ^ round_key);
   end

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         valid_out <= 1'b0;
      end else begin
         valid_out <= valid_in;
      end
   end

   // data and key only move with a valid block
   always_ff @(posedge clk) begin
      if (valid_in) begin
         block_out <= state_next;
         key_out   <= round_key;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AES testbench with Verilator.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
   --top-module aes_tb \
   -f all.f \
   -o aes_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

# assertion errors should not stop the run before the summary line
sim_out=$(./obj_dir/aes_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if grep -qx "TEST OK" <<< "$sim_out"; then
   exit 0
fi

echo "pass line not found in simulation output"
exit 1

/* tb/aes_tb.sv */
// ============================================================
// testbench for aes_encrypt_top with CREDITS = 4
// vectors come from tb/aes_vectors.txt, run from the project root
// sink model returns one credit per output, at most one per cycle
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_tb import aes_pkg::*; ();

   localparam int CREDITS    = 4;
   localparam int RST_CYCLES = 4;
   localparam int WAIT_LIMIT = 300;  // cycles per wait loop

   logic       clk;
   logic       nRst;
   logic       key_load;
   aes_block_t key_in;
   logic       in_valid;
   aes_block_t in_block;
   logic       in_ready;
   logic       out_valid;
   aes_block_t out_block;
   logic       credit_return;

   aes_block_t vec_key [$];
   aes_block_t vec_pt  [$];
   aes_block_t vec_ct  [$];

   aes_block_t exp_q      [$];  // scoreboard, accept order
   int         acc_cyc_q  [$];
   int         credit_due [$];  // cycle at which the sink frees a slot
   aes_block_t cur_exp;         // expected ciphertext of the block on in_block

   int          cyc;
   int          accept_cnt;
   int          output_cnt;
   int          check_cnt;
   int          error_cnt;
   int          assert_fails;
   int          release_cnt;
   bit          hold_credits;
   bit          random_sink;
   logic [31:0] lcg_state;

   aes_encrypt_top #(
      .CREDITS (CREDITS)
   ) DUT (
      .clk           (clk),
      .nRst          (nRst),
      .key_load      (key_load),
      .key_in        (key_in),
      .in_valid      (in_valid),
      .in_block      (in_block),
      .in_ready      (in_ready),
      .out_valid     (out_valid),
      .out_block     (out_block),
      .credit_return (credit_return)
   );

   always #50 clk = ~clk;

   function automatic int unsigned rand_below(int unsigned n);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 16) % n;  // low bits of an lcg are weak
   endfunction

   task automatic check_block(string what, aes_block_t got, aes_block_t exp);
      check_cnt++;
      if (got !== exp) begin
         error_cnt++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(string what, logic got, logic exp);
      check_cnt++;
      if (got !== exp) begin
         error_cnt++;
         $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic note_timeout(string what);
      error_cnt++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   task automatic read_vectors();
      int           fd;
      int           n;
      int           code;
      string        line;
      logic [127:0] k;
      logic [127:0] p;
      logic [127:0] c;
      n  = 0;
      fd = $fopen("tb/aes_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open tb/aes_vectors.txt");
      end else begin
         while (!$feof(fd) && n < 64) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
               if ($sscanf(line, "%h %h %h", k, p, c) == 3) begin
                  vec_key.push_back(k);
                  vec_pt.push_back(p);
                  vec_ct.push_back(c);
               end
            end
            n++;
         end
         $fclose(fd);
      end
   endtask

   // scoreboard, sampled on the rising edge before the DUT updates
   always @(posedge clk) begin
      cyc++;
      if (nRst) begin
         if (in_valid && in_ready) begin
            exp_q.push_back(cur_exp);
            acc_cyc_q.push_back(cyc);
            accept_cnt++;
         end
         if (out_valid) begin
            output_cnt++;
            if (exp_q.size() == 0) begin
               error_cnt++;
               $display("output at %0t while no block was in flight", $time);
            end else begin
               check_block("ciphertext", out_block, exp_q.pop_front());
               check_flag("latency of 11", (cyc - acc_cyc_q.pop_front()) == AES_LATENCY,
                          1'b1);
            end
            credit_due.push_back(cyc + (random_sink ? rand_below(6) : 0));
         end
      end
   end

   // sink side credit returns
   always @(negedge clk) begin
      if (nRst && credit_due.size() > 0 &&
          (release_cnt > 0 || (!hold_credits && credit_due[0] <= cyc))) begin
         credit_return = 1'b1;
         void'(credit_due.pop_front());
         if (release_cnt > 0) release_cnt--;
      end else begin
         credit_return = 1'b0;
      end
   end

   // called on a falling edge with in_valid low
   task automatic wait_ready();
      int n;
      n = 0;
      while (!in_ready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!in_ready) begin
         note_timeout("in_ready never came back high");
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() > 0 || credit_due.size() > 0) && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() > 0 || credit_due.size() > 0) begin
         note_timeout("pipeline did not drain");
      end
   endtask

   task automatic load_key(aes_block_t k);
      key_load = 1'b1;
      key_in   = k;
      @(negedge clk);
      key_load = 1'b0;
   endtask

   // one block, optionally with the next key loaded in the same cycle
   task automatic send_block(aes_block_t pt, aes_block_t exp, bit load_next,
                             aes_block_t next_key);
      wait_ready();
      in_valid = 1'b1;
      in_block = pt;
      cur_exp  = exp;
      key_load = load_next;
      key_in   = next_key;
      @(negedge clk);
      in_valid = 1'b0;
      key_load = 1'b0;
   endtask

   initial begin
      int base;
      int nv;
      int j;
      int j_next;
      clk           = 1'b0;
      nRst          = 1'b0;
      key_load      = 1'b0;
      key_in        = '0;
      in_valid      = 1'b0;
      in_block      = '0;
      credit_return = 1'b0;
      cur_exp       = '0;
      cyc           = 0;
      accept_cnt    = 0;
      output_cnt    = 0;
      check_cnt     = 0;
      error_cnt     = 0;
      release_cnt   = 0;
      hold_credits  = 1'b0;
      random_sink   = 1'b0;
      lcg_state     = 32'd91103;

      read_vectors();
      nv = vec_key.size();

      repeat (RST_CYCLES) @(negedge clk);
      nRst = 1'b1;
      @(negedge clk);
      check_flag("out_valid after reset", out_valid, 1'b0);
      check_flag("in_ready after reset", in_ready, 1'b1);

      if (nv == 0) begin
         error_cnt++;
         $display("no vectors found in tb/aes_vectors.txt");
      end else begin
         // each vector on its own
         for (int i = 0; i < nv; i++) begin
            load_key(vec_key[i]);
            send_block(vec_pt[i], vec_ct[i], 1'b0, vec_key[i]);
            wait_drain();
         end

         // back to back, next key written in the cycle of each accept
         load_key(vec_key[0]);
         for (int i = 0; i < nv; i++) begin
            send_block(vec_pt[i], vec_ct[i], (i + 1 < nv), vec_key[(i + 1) % nv]);
         end
         wait_drain();

         // credits held back by the sink
         load_key(vec_key[0]);
         hold_credits = 1'b1;
         base         = accept_cnt;
         in_valid     = 1'b1;
         in_block     = vec_pt[0];
         cur_exp      = vec_ct[0];
         repeat (20) @(negedge clk);
         check_flag("accepts limited to the credits", (accept_cnt - base) == CREDITS, 1'b1);
         check_flag("in_ready with no credit left", in_ready, 1'b0);
         @(posedge clk);
         release_cnt = 1;
         repeat (8) @(negedge clk);
         check_flag("one accept per returned credit", (accept_cnt - base) == CREDITS + 1,
                    1'b1);
         check_flag("in_ready after the spent credit", in_ready, 1'b0);
         in_valid = 1'b0;
         @(posedge clk);
         hold_credits = 1'b0;
         @(negedge clk);
         wait_drain();

         // random gaps and random sink delays
         random_sink = 1'b1;
         j = rand_below(nv);
         load_key(vec_key[j]);
         for (int s = 0; s < 3 * nv; s++) begin
            j_next = rand_below(nv);
            repeat (rand_below(4)) @(negedge clk);
            send_block(vec_pt[j], vec_ct[j], 1'b1, vec_key[j_next]);
            j = j_next;
         end
         wait_drain();
         check_flag("outputs equal accepts", output_cnt == accept_cnt, 1'b1);
      end

      assert_fails = DUT.u_asserts.fail_accept + DUT.u_asserts.fail_latency +
                     DUT.u_asserts.fail_credit;
      $display("%0d checks, %0d errors, %0d assertion failures, %0d accepted, %0d out",
               check_cnt, error_cnt, assert_fails, accept_cnt, output_cnt);
      if (error_cnt == 0 && assert_fails == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/aes_tb_asserts.sv */
// ============================================================
// protocol checks on aes_encrypt_top, bound into every instance
// the credit model assumes the counter reset value is CREDITS
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module aes_tb_asserts import aes_pkg::*; #(
   parameter int CREDITS = 4
) (
   input logic clk,
   input logic nRst,
   input logic in_valid,
   input logic in_ready,
   input logic accept,
   input logic out_valid,
   input logic credit_return
);

   logic                   handshake;    // accept as seen on the ports
   logic [AES_LATENCY-1:0] accept_hist;  // bit k set when handshake was k+1 edges ago
   int                     credit_model;

   int fail_accept  = 0;
   int fail_latency = 0;
   int fail_credit  = 0;

   assign handshake = in_valid && in_ready;

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         accept_hist  <= '0;
         credit_model <= CREDITS;
      end else begin
         accept_hist <= {accept_hist[AES_LATENCY-2:0], handshake};
         if (handshake && !credit_return) begin
            credit_model <= credit_model - 1;
         end else if (!handshake && credit_return) begin
            credit_model <= credit_model + 1;
         end
      end
   end

   a_accept_needs_credit: assert property (@(posedge clk) disable iff (!nRst)
      (credit_model == 0) |-> (!in_ready && !accept))
      else begin
         $error("in_ready or accept high with no credit left");
         fail_accept++;
      end

   a_fixed_latency: assert property (@(posedge clk) disable iff (!nRst)
      out_valid == accept_hist[AES_LATENCY-1])
      else begin
         $error("out_valid not 11 cycles after its accept");
         fail_latency++;
      end

   a_credit_bound: assert property (@(posedge clk) disable iff (!nRst)
      (credit_return && !handshake) |-> (credit_model < CREDITS))
      else begin
         $error("credit returned beyond CREDITS");
         fail_credit++;
      end

endmodule

bind aes_encrypt_top aes_tb_asserts #(
   .CREDITS (CREDITS)
) u_asserts (
   .clk           (clk),
   .nRst          (nRst),
   .in_valid      (in_valid),
   .in_ready      (in_ready),
   .accept        (accept),
   .out_valid     (out_valid),
   .credit_return (credit_return)
);

`default_nettype wire

/* tb/aes_vectors.txt */
# columns: key, plaintext, expected ciphertext; 32 hex digits each
# byte 0 of FIPS-197 is the leftmost pair of digits
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
